// File: clock_consts.svh
`ifndef CLOCK_CONSTS_SVH
`define CLOCK_CONSTS_SVH

// consecutive high samples before a button fires
`define HOLD_CYCLES 3

// mode code that allows editing
`define SET_MODE 4'd0

// year x4, month, day, hour, minute, second x2
`define NUM_DIGITS 14

// 2023-01-01 00:00:00 in bcd
`define RESET_WORD 56'h2023_0101_000000

`endif

// File: clock_pkg.sv
`default_nettype none

`include "clock_consts.svh"

package clock_pkg;

    typedef logic [3:0] bcd_t;

    // 0 is seconds units, 13 is year thousands
    typedef logic [3:0] cursor_t;

    typedef struct packed {
        logic [15:0] year;
        logic [7:0]  month;
        logic [7:0]  day;
        logic [7:0]  hour;
        logic [7:0]  minute;
        logic [7:0]  sec;
    } clock_fields_t;

    // same 56 bits seen as calendar fields or as cursor-indexed digits
    typedef union packed {
        clock_fields_t                fields;
        bcd_t [`NUM_DIGITS-1:0]       digits;
    } clock_word_u;

endpackage

`default_nettype wire

// File: button_pulse.sv
`timescale 1ns/1ps
`default_nettype none

`include "clock_consts.svh"

module button_pulse (
    input  logic clk,
    input  logic start_set,
    input  logic button,
    output logic pulse
);

    localparam int CNT_W = $clog2(`HOLD_CYCLES + 2);
    localparam logic [CNT_W-1:0] HOLD = CNT_W'(`HOLD_CYCLES);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`HOLD_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;

    always_ff @(posedge clk or posedge start_set) begin
        if (start_set) begin
            hold_cnt <= '0;
        end else if (!button) begin
            hold_cnt <= '0;                 // release rearms
        end else if (hold_cnt != CNT_MAX) begin
            hold_cnt <= hold_cnt + 1'b1;    // parks past HOLD so it never repeats
        end
    end

    always_ff @(posedge clk or posedge start_set) begin
        if (start_set) begin
            pulse <= 1'b0;
        end else begin
            pulse <= (hold_cnt == HOLD);
        end
    end

    a_single_pulse: assert property (
        @(posedge clk) disable iff (start_set)
        pulse |=> !pulse
    ) else $error("button_pulse fired on two cycles in a row");

endmodule

`default_nettype wire

// File: cursor_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "clock_consts.svh"

module cursor_ctrl (
    input  logic               clk,
    input  logic               start_set,
    input  logic [3:0]         mode,
    input  logic               left_pulse,
    input  logic               right_pulse,
    output clock_pkg::cursor_t cursor
);

    import clock_pkg::*;

    localparam cursor_t TOP = cursor_t'(`NUM_DIGITS - 1);

    logic set_mode;

    assign set_mode = (mode == `SET_MODE);

    always_ff @(posedge clk or posedge start_set) begin
        if (start_set) begin
            cursor <= TOP;                  // start on year thousands
        end else if (set_mode) begin
            if (left_pulse) begin
                if (cursor == TOP) begin
                    cursor <= '0;
                end else begin
                    cursor <= cursor + 1'b1;
                end
            end else if (right_pulse) begin
                if (cursor == '0) begin
                    cursor <= TOP;
                end else begin
                    cursor <= cursor - 1'b1;
                end
            end
        end
    end

    // the editor indexes its digit array with this value
    a_cursor_range: assert property (
        @(posedge clk) disable iff (start_set)
        cursor <= TOP
    ) else $error("cursor left the digit range");

endmodule

`default_nettype wire

// File: digit_editor.sv
`timescale 1ns/1ps
`default_nettype none

`include "clock_consts.svh"

module digit_editor (
    input  logic               clk,
    input  logic               start_set,
    input  logic [3:0]         mode,
    input  logic               up_pulse,
    input  logic               down_pulse,
    input  clock_pkg::cursor_t cursor,
    output logic [15:0]        year,
    output logic [7:0]         month,
    output logic [7:0]         day,
    output logic [7:0]         hour,
    output logic [7:0]         minute,
    output logic [7:0]         sec
);

    import clock_pkg::*;

    clock_word_u word_q;
    logic [13:0] year_bin;
    logic [6:0]  month_bin;
    logic        leap;
    bcd_t        last_t;
    bcd_t        last_u;
    bcd_t        lo;
    bcd_t        hi;
    bcd_t        cur_digit;
    bcd_t        next_digit;
    logic        edit_en;

    function automatic logic digits_valid(clock_word_u w);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < `NUM_DIGITS; i++) begin
            if (w.digits[i] > 4'd9) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    assign year_bin = 14'(word_q.fields.year[15:12]) * 14'd1000
                    + 14'(word_q.fields.year[11:8]) * 14'd100
                    + 14'(word_q.fields.year[7:4]) * 14'd10
                    + 14'(word_q.fields.year[3:0]);

    assign month_bin = 7'(word_q.fields.month[7:4]) * 7'd10
                     + 7'(word_q.fields.month[3:0]);

    assign leap = (year_bin % 14'd400 == 14'd0) ||
                  ((year_bin % 14'd4 == 14'd0) && (year_bin % 14'd100 != 14'd0));

    // last day of the month as two bcd digits
    always_comb begin
        case (month_bin)
            7'd2: begin
                last_t = 4'd2;
                last_u = leap ? 4'd9 : 4'd8;
            end
            7'd4, 7'd6, 7'd9, 7'd11: begin
                last_t = 4'd3;
                last_u = 4'd0;
            end
            default: begin
                last_t = 4'd3;
                last_u = 4'd1;
            end
        endcase
    end

    // range of the digit under the cursor
    always_comb begin
        lo = 4'd0;
        hi = 4'd9;
        case (cursor)
            4'd1, 4'd3: hi = 4'd5;          // seconds and minutes tens
            4'd5:       hi = 4'd2;          // hour tens
            4'd6: begin                     // day units
                if (word_q.fields.day[7:4] == last_t) begin
                    hi = last_u;
                end else if (word_q.fields.day[7:4] > last_t) begin
                    hi = 4'd0;
                end
            end
            4'd7:       hi = (month_bin == 7'd2) ? 4'd2 : 4'd3;
            4'd8: begin                     // month units
                if (word_q.fields.month[7:4] == 4'd0) begin
                    lo = 4'd1;
                end else begin
                    hi = 4'd2;
                end
            end
            4'd9:       hi = 4'd1;
            default:    hi = 4'd9;          // units of time and year digits
        endcase
    end

    assign cur_digit = word_q.digits[cursor];

    always_comb begin
        if (up_pulse) begin
            next_digit = (cur_digit >= hi) ? lo : cur_digit + 1'b1;
        end else begin
            next_digit = (cur_digit <= lo) ? hi : cur_digit - 1'b1;
        end
    end

    assign edit_en = (mode == `SET_MODE) && (up_pulse || down_pulse);

    always_ff @(posedge clk or posedge start_set) begin
        if (start_set) begin
            word_q <= `RESET_WORD;
        end else if (edit_en) begin
            word_q.digits[cursor] <= next_digit;   // other digits untouched
        end
    end

    assign year   = word_q.fields.year;
    assign month  = word_q.fields.month;
    assign day    = word_q.fields.day;
    assign hour   = word_q.fields.hour;
    assign minute = word_q.fields.minute;
    assign sec    = word_q.fields.sec;

    a_digits_bcd: assert property (
        @(posedge clk) disable iff (start_set)
        digits_valid(word_q)
    ) else $error("digit_editor holds a non-bcd digit");

endmodule

`default_nettype wire

// File: weekday_calc.sv
`timescale 1ns/1ps
`default_nettype none

module weekday_calc (
    input  logic        clk,
    input  logic        start_set,
    input  logic [15:0] year,
    input  logic [7:0]  month,
    input  logic [7:0]  day,
    output logic [3:0]  week
);

    logic [13:0] year_bin;
    logic [6:0]  month_bin;
    logic [6:0]  day_bin;
    logic        early;
    logic [6:0]  m_f;
    logic [13:0] y_f;
    logic [15:0] sum;

    assign year_bin = 14'(year[15:12]) * 14'd1000 + 14'(year[11:8]) * 14'd100
                    + 14'(year[7:4]) * 14'd10 + 14'(year[3:0]);
    assign month_bin = 7'(month[7:4]) * 7'd10 + 7'(month[3:0]);
    assign day_bin   = 7'(day[7:4]) * 7'd10 + 7'(day[3:0]);

    assign early = (month_bin == 7'd1) || (month_bin == 7'd2);   // jan, feb
    assign m_f   = early ? month_bin + 7'd12 : month_bin;

    // shifted by one 400-year cycle so year 0000 cannot go negative
    assign y_f = year_bin + 14'd400 - (early ? 14'd1 : 14'd0);

    assign sum = 16'(day_bin) + 16'(m_f) * 16'd2 + (16'(m_f) + 16'd1) * 16'd3 / 16'd5
               + 16'(y_f) + 16'(y_f) / 16'd4 - 16'(y_f) / 16'd100 + 16'(y_f) / 16'd400
               + 16'd1;

    always_ff @(posedge clk or posedge start_set) begin
        if (start_set) begin
            week <= 4'd0;
        end else begin
            week <= 4'(sum % 16'd7);     // 0 is sunday
        end
    end

endmodule

`default_nettype wire

// File: time_setter.sv
`timescale 1ns/1ps
`default_nettype none

module time_setter (
    input  logic        clk,
    input  logic        start_set,
    input  logic [3:0]  mode,
    input  logic        button_l,
    input  logic        button_r,
    input  logic        button_up,
    input  logic        button_down,
    output logic [15:0] year,
    output logic [7:0]  month,
    output logic [7:0]  day,
    output logic [7:0]  hour,
    output logic [7:0]  minute,
    output logic [7:0]  sec,
    output logic [3:0]  week
);

    import clock_pkg::*;

    logic    pulse_l;
    logic    pulse_r;
    logic    pulse_up;
    logic    pulse_down;
    cursor_t cursor;

    button_pulse u_pulse_l (
        .clk       (clk),
        .start_set (start_set),
        .button    (button_l),
        .pulse     (pulse_l)
    );

    button_pulse u_pulse_r (
        .clk       (clk),
        .start_set (start_set),
        .button    (button_r),
        .pulse     (pulse_r)
    );

    button_pulse u_pulse_up (
        .clk       (clk),
        .start_set (start_set),
        .button    (button_up),
        .pulse     (pulse_up)
    );

    button_pulse u_pulse_down (
        .clk       (clk),
        .start_set (start_set),
        .button    (button_down),
        .pulse     (pulse_down)
    );

    cursor_ctrl u_cursor_ctrl (
        .clk         (clk),
        .start_set   (start_set),
        .mode        (mode),
        .left_pulse  (pulse_l),
        .right_pulse (pulse_r),
        .cursor      (cursor)
    );

    digit_editor u_digit_editor (
        .clk        (clk),
        .start_set  (start_set),
        .mode       (mode),
        .up_pulse   (pulse_up),
        .down_pulse (pulse_down),
        .cursor     (cursor),
        .year       (year),
        .month      (month),
        .day        (day),
        .hour       (hour),
        .minute     (minute),
        .sec        (sec)
    );

    weekday_calc u_weekday_calc (
        .clk       (clk),
        .start_set (start_set),
        .year      (year),
        .month     (month),
        .day       (day),
        .week      (week)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// File: tb_time_setter.sv
`timescale 1ns/1ps
`default_nettype none

`include "clock_consts.svh"

module tb_time_setter;

    import clock_pkg::*;

    localparam int BTN_L = 0;
    localparam int BTN_R = 1;
    localparam int BTN_UP = 2;
    localparam int BTN_DOWN = 3;
    localparam int CHECK_TIMEOUT = 20;
    localparam cursor_t TOP_CURSOR = cursor_t'(`NUM_DIGITS - 1);

    logic        clk;
    logic        start_set;
    logic [3:0]  mode;
    logic        button_l;
    logic        button_r;
    logic        button_up;
    logic        button_down;
    logic [15:0] year;
    logic [7:0]  month;
    logic [7:0]  day;
    logic [7:0]  hour;
    logic [7:0]  minute;
    logic [7:0]  sec;
    logic [3:0]  week;

    cursor_t     cursor_m;
    clock_word_u word_m;
    int          req_id;
    int          done_id;
    int          seed;
    string       test_name;

    tb_clk_gen u_clk_gen (
        .clk (clk)
    );

    time_setter u_time_setter (
        .clk         (clk),
        .start_set   (start_set),
        .mode        (mode),
        .button_l    (button_l),
        .button_r    (button_r),
        .button_up   (button_up),
        .button_down (button_down),
        .year        (year),
        .month       (month),
        .day         (day),
        .hour        (hour),
        .minute      (minute),
        .sec         (sec),
        .week        (week)
    );

    function automatic int bcd_to_int(logic [15:0] b);
        return b[15:12] * 1000 + b[11:8] * 100 + b[7:4] * 10 + b[3:0];
    endfunction

    function automatic int month_days(int y, int m);
        bit leap;
        leap = (y % 400 == 0) || ((y % 4 == 0) && (y % 100 != 0));
        case (m)
            2:           return leap ? 29 : 28;
            4, 6, 9, 11: return 30;
            default:     return 31;
        endcase
    endfunction

    // next value of digit c after one up or down step
    function automatic bcd_t step_digit(clock_word_u w, cursor_t c, bit up);
        int last;
        int lo;
        int hi;
        int v;
        int day_t;
        last = month_days(bcd_to_int(w.fields.year), bcd_to_int(w.fields.month));
        day_t = w.fields.day[7:4];
        lo = 0;
        hi = 9;
        v = w.digits[c];
        case (c)
            1, 3: hi = 5;
            5:    hi = 2;
            6:    hi = (day_t < last / 10) ? 9 : (day_t == last / 10) ? last % 10 : 0;
            7:    hi = last / 10;                  // 3, or 2 in february
            8: begin
                if (w.fields.month[7:4] == 0) begin
                    lo = 1;
                end else begin
                    hi = 2;
                end
            end
            9:    hi = 1;
            default: hi = 9;
        endcase
        if (up) begin
            return bcd_t'((v >= hi) ? lo : v + 1);
        end
        return bcd_t'((v <= lo) ? hi : v - 1);
    endfunction

    function automatic logic [3:0] weekday_ref(clock_word_u w);
        int y;
        int m;
        int d;
        int sum;
        y = bcd_to_int(w.fields.year);
        m = bcd_to_int(w.fields.month);
        d = bcd_to_int(w.fields.day);
        if (m == 1 || m == 2) begin
            m = m + 12;
            y = y - 1;
        end
        y = y + 400;                               // whole number of weeks
        sum = d + 2 * m + 3 * (m + 1) / 5 + y + y / 4 - y / 100 + y / 400 + 1;
        return 4'(sum % 7);
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(string what, int exp, int act);
        assert (exp == act) else
            fail_run($sformatf("Error in %s: %s expected %0h, actual %0h",
                               test_name, what, exp, act));
    endtask

    // compare on the falling edge
    always @(negedge clk) begin
        if (done_id != req_id) begin
            check_value("year", word_m.fields.year, year);
            check_value("month", word_m.fields.month, month);
            check_value("day", word_m.fields.day, day);
            check_value("hour", word_m.fields.hour, hour);
            check_value("minute", word_m.fields.minute, minute);
            check_value("sec", word_m.fields.sec, sec);
            check_value("week", weekday_ref(word_m), week);
            done_id = req_id;
        end
    end

    task automatic request_check();
        int t;
        req_id++;
        for (t = 0; t < CHECK_TIMEOUT && done_id != req_id; t++) begin
            @(posedge clk);
        end
        if (done_id != req_id) begin
            fail_run("the output comparison did not complete in time");
        end
    endtask

    task automatic set_button(int which, logic v);
        case (which)
            BTN_L:   button_l <= v;
            BTN_R:   button_r <= v;
            BTN_UP:  button_up <= v;
            default: button_down <= v;
        endcase
    endtask

    task automatic press(int which);
        int t;
        @(posedge clk);
        set_button(which, 1'b1);
        for (t = 0; t < `HOLD_CYCLES + 4; t++) begin
            @(posedge clk);
        end
        set_button(which, 1'b0);
        for (t = 0; t < 4; t++) begin
            @(posedge clk);
        end
        if (mode == `SET_MODE) begin
            case (which)
                BTN_L:   cursor_m = (cursor_m == TOP_CURSOR) ? '0 : cursor_m + 1'b1;
                BTN_R:   cursor_m = (cursor_m == '0) ? TOP_CURSOR : cursor_m - 1'b1;
                BTN_UP:  word_m.digits[cursor_m] = step_digit(word_m, cursor_m, 1'b1);
                default: word_m.digits[cursor_m] = step_digit(word_m, cursor_m, 1'b0);
            endcase
        end
        request_check();
    endtask

    task automatic move_cursor(cursor_t pos);
        int n;
        for (n = 0; n < `NUM_DIGITS && cursor_m != pos; n++) begin
            if ((pos + `NUM_DIGITS - cursor_m) % `NUM_DIGITS <= `NUM_DIGITS / 2) begin
                press(BTN_L);
            end else begin
                press(BTN_R);
            end
        end
        if (cursor_m != pos) begin
            fail_run("the cursor did not reach the requested digit");
        end
    endtask

    task automatic set_digit(cursor_t pos, bcd_t value);
        int n;
        move_cursor(pos);
        for (n = 0; n < 10 && word_m.digits[pos] != value; n++) begin
            press(BTN_UP);
        end
        if (word_m.digits[pos] != value) begin
            fail_run("a digit could not be stepped to the requested value");
        end
    endtask

    task automatic sweep(cursor_t pos, int ups, int downs);
        move_cursor(pos);
        repeat (ups) press(BTN_UP);
        repeat (downs) press(BTN_DOWN);
    endtask

    initial begin
        int i;
        int r;
        start_set = 1'b1;
        mode = `SET_MODE;
        button_l = 1'b0;
        button_r = 1'b0;
        button_up = 1'b0;
        button_down = 1'b0;
        req_id = 0;
        done_id = 0;
        seed = 42625;
        cursor_m = TOP_CURSOR;
        word_m = `RESET_WORD;
        test_name = "reset";
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        start_set <= 1'b0;
        request_check();

        test_name = "cursor_wrap";
        press(BTN_UP);                             // year thousands
        press(BTN_L);                              // 13 wraps to 0
        press(BTN_UP);
        press(BTN_R);                              // 0 wraps to 13
        press(BTN_UP);
        press(BTN_R);
        press(BTN_UP);

        test_name = "digit_wrap";
        sweep(13, 10, 2);
        sweep(10, 10, 2);
        sweep(9, 2, 2);
        sweep(8, 12, 2);
        sweep(5, 3, 3);
        sweep(4, 10, 1);
        sweep(3, 6, 6);
        sweep(2, 10, 1);
        sweep(1, 6, 6);
        sweep(0, 10, 1);

        test_name = "day_limits";
        set_digit(13, 2);
        set_digit(12, 0);
        set_digit(11, 2);
        set_digit(10, 4);
        set_digit(9, 0);
        set_digit(8, 1);
        set_digit(7, 3);
        sweep(6, 3, 3);                            // 31 days in january
        set_digit(8, 4);
        sweep(6, 2, 2);                            // 30 days in april
        set_digit(8, 2);
        sweep(7, 4, 2);
        set_digit(7, 2);
        sweep(6, 11, 2);                           // february 2024
        set_digit(10, 3);
        set_digit(7, 2);
        sweep(6, 10, 2);                           // february 2023

        test_name = "mode_lock";
        @(posedge clk);
        mode <= 4'd5;
        press(BTN_L);
        press(BTN_UP);
        press(BTN_R);
        press(BTN_DOWN);
        @(posedge clk);
        mode <= `SET_MODE;

        test_name = "random_presses";
        for (i = 0; i < 200; i++) begin
            r = $random(seed);
            press(r & 3);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
clock_pkg.sv
button_pulse.sv
cursor_ctrl.sv
digit_editor.sv
weekday_calc.sv
time_setter.sv
tb_clk_gen.sv
tb_time_setter.sv
